// File: robo_consts.svh
`ifndef ROBO_CONSTS_SVH
`define ROBO_CONSTS_SVH

// Motor and encoder channels on this board
`define NUM_MOTORS 2

// Command bytes in one SPI frame
`define RX_BYTES 5

// First byte on MISO in every frame
`define SPI_VERSION 8'h02

// Highest phase of the triangle PWM counter
`define PWM_TOP 510

// Cycles without a valid frame before the drive is blanked
// Kept short for simulation, a board build raises this
`define WDOG_CYCLES 20000

// Kicker timing in sysclk cycles
`define KICK_TICK 4
`define KICK_LOCKOUT 200

`endif

// File: robo_pkg.sv
`default_nettype none

`include "robo_consts.svh"

package robo_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [8:0] speed_t;
	typedef logic [8:0] pwm_phase_t;
	// Hall code ordered {a, b, c}
	typedef logic [2:0] hall_t;
	// Gates ordered {high_a, low_a, high_b, low_b, high_c, low_c}
	typedef logic [5:0] bridge_t;
	typedef logic [15:0] enc_count_t;

	typedef struct packed {
		logic dir;
		speed_t speed;
	} motor_cmd_t;

	typedef struct packed {
		logic charge_enable;
		logic kick_select;
		byte_t strength;
	} kick_cmd_t;

	typedef struct packed {
		logic [1:0] pad;
		logic kick_select;
		logic charge_override;
		logic charge_enable;
		logic kcharge;
		logic lockout;
		logic done;
	} kick_status_t;

	// Index 0 of enc is encoder 1
	typedef struct packed {
		enc_count_t [`NUM_MOTORS-1:0] enc;
		byte_t fault;
		kick_status_t kick;
	} robo_status_t;

	typedef enum logic [1:0] {
		KICK_READY,
		KICK_FIRE,
		KICK_LOCKOUT
	} kick_state_t;

endpackage

`default_nettype wire

// File: spi_target.sv
`timescale 1ns/1ns
`default_nettype none

`include "robo_consts.svh"

module spi_target import robo_pkg::*; (
	input wire sysclk,
	input wire arst_n,
	input wire fpga_ncs,
	input wire mosi,
	input wire sck,
	input wire robo_status_t status,
	output logic miso,
	output logic miso_en,
	output byte_t [`RX_BYTES-1:0] rx_data,
	output logic frame_done
);

	logic sck_meta, sck_s, sck_d;
	logic mosi_meta, mosi_s, mosi_d;
	logic ncs_meta, ncs_s, ncs_d;
	logic sck_rise, sck_fall;
	logic [2:0] bit_count;
	logic [3:0] byte_count;
	byte_t shift_reg;
	byte_t next_tx;
	logic rx_strobe;
	robo_status_t status_q;

	// Two-flop synchronizers, the _d stages feed edge detection
	always_ff @(posedge sysclk or negedge arst_n) begin
		if (!arst_n) begin
			sck_meta <= 1'b0;
			sck_s <= 1'b0;
			sck_d <= 1'b0;
			mosi_meta <= 1'b0;
			mosi_s <= 1'b0;
			ncs_meta <= 1'b1;
			ncs_s <= 1'b1;
			ncs_d <= 1'b1;
		end else begin
			sck_meta <= sck;
			sck_s <= sck_meta;
			sck_d <= sck_s;
			mosi_meta <= mosi;
			mosi_s <= mosi_meta;
			ncs_meta <= fpga_ncs;
			ncs_s <= ncs_meta;
			ncs_d <= ncs_s;
		end
	end

	assign sck_rise = sck_s && !sck_d;
	assign sck_fall = !sck_s && sck_d;

	// One register shifts MISO out and MOSI in
	always_ff @(posedge sysclk or negedge arst_n) begin
		if (!arst_n) begin
			shift_reg <= `SPI_VERSION;
			bit_count <= '0;
			byte_count <= '0;
			mosi_d <= 1'b0;
			rx_strobe <= 1'b0;
			rx_data <= '0;
		end else begin
			rx_strobe <= 1'b0;
			if (ncs_s) begin
				shift_reg <= `SPI_VERSION;
				bit_count <= '0;
				byte_count <= '0;
			end else begin
				// Middle of a bit
				if (sck_rise) begin
					mosi_d <= mosi_s;
					if (bit_count == 3'd7) begin
						rx_strobe <= 1'b1;
						if (byte_count < 4'(`RX_BYTES)) begin
							rx_data[byte_count] <= {shift_reg[6:0], mosi_s};
						end
					end
				end
				// End of a bit
				if (sck_fall) begin
					bit_count <= bit_count + 3'd1;
					if (bit_count == 3'd7) begin
						shift_reg <= next_tx;
						if (byte_count != 4'hf) begin
							byte_count <= byte_count + 4'd1;
						end
					end else begin
						shift_reg <= {shift_reg[6:0], mosi_d};
					end
				end
			end
		end
	end

	// Whole status frame comes from one instant
	always_ff @(posedge sysclk or negedge arst_n) begin
		if (!arst_n) begin
			status_q <= '0;
		end else if (rx_strobe && byte_count == 4'd0) begin
			status_q <= status;
		end
	end

	// byte_count still holds the byte just finished
	always_comb begin
		case (byte_count)
			4'd0: next_tx = status_q.enc[0][7:0];
			4'd1: next_tx = status_q.enc[0][15:8];
			4'd2: next_tx = status_q.enc[1][7:0];
			4'd3: next_tx = status_q.enc[1][15:8];
			4'd4: next_tx = status_q.fault;
			4'd5: next_tx = status_q.kick;
			default: next_tx = '0;
		endcase
	end

	// Only frames of exactly RX_BYTES whole bytes count
	always_ff @(posedge sysclk or negedge arst_n) begin
		if (!arst_n) begin
			frame_done <= 1'b0;
		end else begin
			frame_done <= ncs_s && !ncs_d && byte_count == 4'(`RX_BYTES) && bit_count == 3'd0;
		end
	end

	assign miso = shift_reg[7];
	assign miso_en = !ncs_s;

endmodule

`default_nettype wire

// File: drive_timebase.sv
`timescale 1ns/1ns
`default_nettype none

`include "robo_consts.svh"

module drive_timebase import robo_pkg::*; (
	input wire sysclk,
	input wire arst_n,
	input wire wdog_restart,
	output pwm_phase_t pwm_phase,
	output logic wdog_expired
);

	localparam int WDOG_W = $clog2(`WDOG_CYCLES + 1);

	logic counting_down;
	logic [WDOG_W-1:0] wdog_count;

	// Triangle 0 -> PWM_TOP -> 0, turning one step early on each side
	always_ff @(posedge sysclk or negedge arst_n) begin
		if (!arst_n) begin
			pwm_phase <= '0;
			counting_down <= 1'b0;
		end else if (!counting_down) begin
			if (pwm_phase == pwm_phase_t'(`PWM_TOP - 1)) begin
				counting_down <= 1'b1;
			end
			pwm_phase <= pwm_phase + 1'b1;
		end else begin
			if (pwm_phase == pwm_phase_t'(1)) begin
				counting_down <= 1'b0;
			end
			pwm_phase <= pwm_phase - 1'b1;
		end
	end

	// Expired from reset until the first frame
	always_ff @(posedge sysclk or negedge arst_n) begin
		if (!arst_n) begin
			wdog_count <= '0;
			wdog_expired <= 1'b1;
		end else if (wdog_restart) begin
			wdog_count <= '0;
			wdog_expired <= 1'b0;
		end else if (!wdog_expired) begin
			if (wdog_count == WDOG_W'(`WDOG_CYCLES - 1)) begin
				wdog_expired <= 1'b1;
			end else begin
				wdog_count <= wdog_count + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: command_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "robo_consts.svh"

module command_regs import robo_pkg::*; (
	input wire sysclk,
	input wire arst_n,
	input wire byte_t [`RX_BYTES-1:0] rx_data,
	input wire frame_done,
	input wire wdog_expired,
	output motor_cmd_t [`NUM_MOTORS-1:0] motor_cmd,
	output kick_cmd_t kick_cmd,
	output logic kick_strobe,
	output logic wdog_restart
);

	// Last motor's high byte also carries the kicker bits
	localparam int CTRL_BYTE = 2 * `NUM_MOTORS - 1;
	localparam int STRENGTH_BYTE = `RX_BYTES - 1;

	always_ff @(posedge sysclk or negedge arst_n) begin
		if (!arst_n) begin
			motor_cmd <= '0;
			kick_cmd <= '0;
			kick_strobe <= 1'b0;
			wdog_restart <= 1'b0;
		end else begin
			kick_strobe <= 1'b0;
			wdog_restart <= frame_done;
			if (frame_done) begin
				for (int i = 0; i < `NUM_MOTORS; i++) begin
					motor_cmd[i].speed <= {rx_data[2*i+1][0], rx_data[2*i]};
					motor_cmd[i].dir <= rx_data[2*i+1][1];
				end
				kick_cmd.charge_enable <= rx_data[CTRL_BYTE][7];
				kick_cmd.kick_select <= rx_data[CTRL_BYTE][6];
				kick_cmd.strength <= rx_data[STRENGTH_BYTE];
				kick_strobe <= (rx_data[STRENGTH_BYTE] != 8'h00);
			end else if (wdog_expired && !wdog_restart) begin
				// Expired flag lags the restart by a cycle, so skip blanking then
				for (int i = 0; i < `NUM_MOTORS; i++) begin
					motor_cmd[i] <= '0;
				end
				kick_cmd.charge_enable <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: bldc_commutator.sv
`timescale 1ns/1ns
`default_nettype none

module bldc_commutator import robo_pkg::*; (
	input wire sysclk,
	input wire arst_n,
	input wire pwm_phase_t pwm_phase,
	input wire motor_cmd_t cmd,
	input wire hall_t hall,
	output bridge_t bridge,
	output logic fault
);

	hall_t hall_meta, hall_s;
	// One-hot phase selects, bit 2 is phase A
	logic [2:0] table_hi, table_lo;
	logic [2:0] drive_hi, drive_lo;
	logic pwm_on;
	logic hall_bad;
	bridge_t bridge_next;

	always_ff @(posedge sysclk or negedge arst_n) begin
		if (!arst_n) begin
			hall_meta <= '0;
			hall_s <= '0;
		end else begin
			hall_meta <= hall;
			hall_s <= hall_meta;
		end
	end

	// Forward six-step table
	always_comb begin
		case (hall_s)
			3'b101: begin table_hi = 3'b100; table_lo = 3'b010; end
			3'b100: begin table_hi = 3'b100; table_lo = 3'b001; end
			3'b110: begin table_hi = 3'b010; table_lo = 3'b001; end
			3'b010: begin table_hi = 3'b010; table_lo = 3'b100; end
			3'b011: begin table_hi = 3'b001; table_lo = 3'b100; end
			3'b001: begin table_hi = 3'b001; table_lo = 3'b010; end
			default: begin table_hi = 3'b000; table_lo = 3'b000; end
		endcase
	end

	assign hall_bad = (hall_s == 3'b000) || (hall_s == 3'b111);

	// dir set runs in reverse
	assign drive_hi = cmd.dir ? table_lo : table_hi;
	assign drive_lo = cmd.dir ? table_hi : table_lo;

	assign pwm_on = cmd.speed > pwm_phase;

	always_comb begin
		if (cmd.speed == '0) begin
			bridge_next = '0;
		end else begin
			bridge_next = {drive_hi[2] & pwm_on, drive_lo[2],
				drive_hi[1] & pwm_on, drive_lo[1],
				drive_hi[0] & pwm_on, drive_lo[0]};
		end
	end

	always_ff @(posedge sysclk or negedge arst_n) begin
		if (!arst_n) begin
			bridge <= '0;
			fault <= 1'b0;
		end else begin
			bridge <= bridge_next;
			fault <= hall_bad;
		end
	end

endmodule

`default_nettype wire

// File: quad_encoder.sv
`timescale 1ns/1ns
`default_nettype none

module quad_encoder import robo_pkg::*; (
	input wire sysclk,
	input wire arst_n,
	input wire enc_a,
	input wire enc_b,
	output enc_count_t count
);

	logic [1:0] ab_meta, ab_s, ab_d;
	logic a_moved, b_moved;

	always_ff @(posedge sysclk or negedge arst_n) begin
		if (!arst_n) begin
			ab_meta <= '0;
			ab_s <= '0;
			ab_d <= '0;
		end else begin
			ab_meta <= {enc_a, enc_b};
			ab_s <= ab_meta;
			ab_d <= ab_s;
		end
	end

	assign a_moved = ab_s[1] ^ ab_d[1];
	assign b_moved = ab_s[0] ^ ab_d[0];

	// A leads when new A differs from old B; both moving at once is dropped
	always_ff @(posedge sysclk or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else if (a_moved ^ b_moved) begin
			if (ab_s[1] ^ ab_d[0]) begin
				count <= count + 1'b1;
			end else begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: kicker_fsm.sv
`timescale 1ns/1ns
`default_nettype none

`include "robo_consts.svh"

module kicker_fsm import robo_pkg::*; (
	input wire sysclk,
	input wire arst_n,
	input wire kick_strobe,
	input wire kick_cmd_t kick_cmd,
	input wire discharge,
	input wire kdone,
	output logic kcharge,
	output logic kkick,
	output logic kchip,
	output kick_status_t status
);

	localparam int FIRE_MAX = 255 * `KICK_TICK;
	localparam int DUR_MAX = (FIRE_MAX > `KICK_LOCKOUT) ? FIRE_MAX : `KICK_LOCKOUT;
	localparam int DUR_W = $clog2(DUR_MAX + 1);

	kick_state_t state;
	logic [DUR_W-1:0] duration;
	logic button_meta, button_s;
	logic done_meta, done_s;
	logic charge_override;
	logic fire_select;
	logic fire_start;
	logic kick_pulse;
	byte_t fire_strength;

	// Button and done inputs are active low
	always_ff @(posedge sysclk or negedge arst_n) begin
		if (!arst_n) begin
			button_meta <= 1'b0;
			button_s <= 1'b0;
			done_meta <= 1'b0;
			done_s <= 1'b0;
			charge_override <= 1'b0;
		end else begin
			button_meta <= ~discharge;
			button_s <= button_meta;
			done_meta <= ~kdone;
			done_s <= done_meta;
			if (button_s) begin
				charge_override <= 1'b1;
			end
		end
	end

	// Manual discharge dumps the caps at full strength
	assign fire_start = button_s || kick_strobe;
	assign fire_strength = button_s ? 8'hff : kick_cmd.strength;

	always_ff @(posedge sysclk or negedge arst_n) begin
		if (!arst_n) begin
			state <= KICK_READY;
			duration <= '0;
			fire_select <= 1'b0;
		end else begin
			case (state)
				KICK_READY: begin
					if (fire_start) begin
						state <= KICK_FIRE;
						duration <= DUR_W'(int'(fire_strength) * `KICK_TICK - 1);
						fire_select <= kick_cmd.kick_select;
					end
				end
				KICK_FIRE: begin
					if (duration == '0) begin
						state <= KICK_LOCKOUT;
						duration <= DUR_W'(`KICK_LOCKOUT - 1);
					end else begin
						duration <= duration - 1'b1;
					end
				end
				KICK_LOCKOUT: begin
					if (duration == '0) begin
						state <= KICK_READY;
					end else begin
						duration <= duration - 1'b1;
					end
				end
				default: state <= KICK_READY;
			endcase
		end
	end

	assign kick_pulse = (state == KICK_FIRE);
	assign kkick = kick_pulse && !fire_select;
	assign kchip = kick_pulse && fire_select;
	// No charging while firing or locked out
	assign kcharge = (state == KICK_READY) && kick_cmd.charge_enable && !charge_override;

	assign status = '{
		pad: 2'b00,
		kick_select: kick_cmd.kick_select,
		charge_override: charge_override,
		charge_enable: kick_cmd.charge_enable,
		kcharge: kcharge,
		lockout: (state == KICK_LOCKOUT),
		done: done_s
	};

endmodule

`default_nettype wire

// File: robo_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "robo_consts.svh"

module robo_top import robo_pkg::*; (
	input wire sysclk,
	input wire arst_n,
	input wire hall_t [`NUM_MOTORS-1:0] hall,
	output bridge_t [`NUM_MOTORS-1:0] bridge,
	input wire [`NUM_MOTORS-1:0] enc_a,
	input wire [`NUM_MOTORS-1:0] enc_b,
	input wire discharge,
	input wire kdone,
	input wire fpga_ncs,
	input wire mosi,
	input wire sck,
	output logic kcharge,
	output logic kkick,
	output logic kchip,
	output logic miso,
	output logic miso_en
);

	byte_t [`RX_BYTES-1:0] rx_data;
	logic frame_done;
	logic wdog_restart;
	logic wdog_expired;
	pwm_phase_t pwm_phase;
	motor_cmd_t [`NUM_MOTORS-1:0] motor_cmd;
	kick_cmd_t kick_cmd;
	logic kick_strobe;
	logic [`NUM_MOTORS-1:0] fault;
	enc_count_t [`NUM_MOTORS-1:0] enc_count;
	kick_status_t kick_status;
	robo_status_t status;

	// Fault bit n-1 belongs to motor n
	assign status = '{
		enc: enc_count,
		fault: byte_t'(fault),
		kick: kick_status
	};

	spi_target spi_target_i (
		.sysclk(sysclk),
		.arst_n(arst_n),
		.fpga_ncs(fpga_ncs),
		.mosi(mosi),
		.sck(sck),
		.status(status),
		.miso(miso),
		.miso_en(miso_en),
		.rx_data(rx_data),
		.frame_done(frame_done)
	);

	drive_timebase drive_timebase_i (
		.sysclk(sysclk),
		.arst_n(arst_n),
		.wdog_restart(wdog_restart),
		.pwm_phase(pwm_phase),
		.wdog_expired(wdog_expired)
	);

	command_regs command_regs_i (
		.sysclk(sysclk),
		.arst_n(arst_n),
		.rx_data(rx_data),
		.frame_done(frame_done),
		.wdog_expired(wdog_expired),
		.motor_cmd(motor_cmd),
		.kick_cmd(kick_cmd),
		.kick_strobe(kick_strobe),
		.wdog_restart(wdog_restart)
	);

	for (genvar i = 0; i < `NUM_MOTORS; i++) begin : g_motor
		bldc_commutator bldc_commutator_i (
			.sysclk(sysclk),
			.arst_n(arst_n),
			.pwm_phase(pwm_phase),
			.cmd(motor_cmd[i]),
			.hall(hall[i]),
			.bridge(bridge[i]),
			.fault(fault[i])
		);

		quad_encoder quad_encoder_i (
			.sysclk(sysclk),
			.arst_n(arst_n),
			.enc_a(enc_a[i]),
			.enc_b(enc_b[i]),
			.count(enc_count[i])
		);
	end

	kicker_fsm kicker_fsm_i (
		.sysclk(sysclk),
		.arst_n(arst_n),
		.kick_strobe(kick_strobe),
		.kick_cmd(kick_cmd),
		.discharge(discharge),
		.kdone(kdone),
		.kcharge(kcharge),
		.kkick(kkick),
		.kchip(kchip),
		.status(kick_status)
	);

endmodule

`default_nettype wire

// File: tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS = 8,
	parameter int RESET_CYCLES = 8
) (
	output logic sysclk,
	output logic arst_n
);

	initial begin
		sysclk = 1'b0;
		forever #(PERIOD_NS / 2) sysclk = ~sysclk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge sysclk);
		arst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// File: tb_robo.sv
`timescale 1ns/1ns
`default_nettype none

`include "robo_consts.svh"

module tb_robo import robo_pkg::*; ();

	localparam int CLK_NS = 8;
	localparam int SCK_HALF = 6;
	localparam int STATUS_BYTES = 7;
	localparam int PWM_PERIOD = 2 * `PWM_TOP;
	// Watchdog test plus room for all the other tests
	localparam int RUN_CYCLES = `WDOG_CYCLES + 30000;

	logic sysclk;
	logic arst_n;
	hall_t [`NUM_MOTORS-1:0] hall;
	bridge_t [`NUM_MOTORS-1:0] bridge;
	logic [`NUM_MOTORS-1:0] enc_a;
	logic [`NUM_MOTORS-1:0] enc_b;
	logic discharge;
	logic kdone;
	logic fpga_ncs;
	logic mosi;
	logic sck;
	logic kcharge;
	logic kkick;
	logic kchip;
	logic miso;
	logic miso_en;

	integer seed;
	int errors;
	int tests_run;
	int tests_failed;
	int test_start_errors;
	byte_t tx_buf[8];
	byte_t rx_buf[8];
	int enc_phase[`NUM_MOTORS];
	int enc_expect[`NUM_MOTORS];

	// Six-step table with the high and low phase per Hall code
	// Phase 0 is A
	hall_t step_hall[6] = '{3'b101, 3'b100, 3'b110, 3'b010, 3'b011, 3'b001};
	int step_hi[6] = '{0, 0, 1, 1, 2, 2};
	int step_lo[6] = '{1, 2, 2, 0, 0, 1};

	tb_clock #(
		.PERIOD_NS(CLK_NS),
		.RESET_CYCLES(8)
	) tb_clock_i (
		.sysclk(sysclk),
		.arst_n(arst_n)
	);

	robo_top robo_top_i (
		.sysclk(sysclk),
		.arst_n(arst_n),
		.hall(hall),
		.bridge(bridge),
		.enc_a(enc_a),
		.enc_b(enc_b),
		.discharge(discharge),
		.kdone(kdone),
		.fpga_ncs(fpga_ncs),
		.mosi(mosi),
		.sck(sck),
		.kcharge(kcharge),
		.kkick(kkick),
		.kchip(kchip),
		.miso(miso),
		.miso_en(miso_en)
	);

	function automatic bridge_t expected_gates(hall_t code, logic dir, logic high_on);
		bridge_t gates;
		int hi;
		int lo;
		gates = '0;
		for (int i = 0; i < 6; i++) begin
			if (step_hall[i] == code) begin
				// Reverse swaps the driven phases
				hi = dir ? step_lo[i] : step_hi[i];
				lo = dir ? step_hi[i] : step_lo[i];
				gates[5 - 2 * hi] = high_on;
				gates[4 - 2 * lo] = 1'b1;
			end
		end
		return gates;
	endfunction

	task report_mismatch(input string name, input logic [31:0] got, input logic [31:0] expected);
		$display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
		errors++;
	endtask

	task report_failure(input string what);
		$display("ERROR at %0t ns: %s", $time, what);
		errors++;
	endtask

	task finish_test(input string name);
		tests_run++;
		if (errors == test_start_errors) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, errors - test_start_errors);
		end
	endtask

	// Mode 0 frame sent MSB first with one MISO byte kept per byte
	task spi_frame(input int count);
		byte_t out_byte;
		byte_t in_byte;
		repeat (8) @(posedge sysclk);
		fpga_ncs <= 1'b0;
		repeat (SCK_HALF) @(posedge sysclk);
		for (int n = 0; n < count; n++) begin
			out_byte = tx_buf[n];
			for (int b = 7; b >= 0; b--) begin
				mosi <= out_byte[b];
				repeat (SCK_HALF - 1) @(posedge sysclk);
				@(negedge sysclk);
				in_byte[b] = miso;
				if (miso_en !== 1'b1) begin
					report_mismatch("miso_en", miso_en, 1'b1);
				end
				@(posedge sysclk);
				sck <= 1'b1;
				repeat (SCK_HALF) @(posedge sysclk);
				sck <= 1'b0;
			end
			rx_buf[n] = in_byte;
		end
		repeat (SCK_HALF) @(posedge sysclk);
		fpga_ncs <= 1'b1;
		repeat (2) @(posedge sysclk);
	endtask

	// Same speed and direction on both motors
	task send_command(input speed_t speed, input logic dir, input logic charge,
		input logic select, input byte_t strength);
		tx_buf[0] = speed[7:0];
		tx_buf[1] = {6'b0, dir, speed[8]};
		tx_buf[2] = speed[7:0];
		tx_buf[3] = {charge, select, 4'b0, dir, speed[8]};
		tx_buf[4] = strength;
		spi_frame(`RX_BYTES);
	endtask

	// Seven bytes is not a command length, so only status comes back
	task read_status();
		for (int n = 0; n < 8; n++) begin
			tx_buf[n] = 8'h00;
		end
		spi_frame(STATUS_BYTES);
	endtask

	task hall_step(input int m, input hall_t code);
		@(posedge sysclk);
		hall[m] <= code;
		// Two synchronizer flops and the output register
		repeat (4) @(posedge sysclk);
		@(negedge sysclk);
	endtask

	// Gray sequence of {a, b} where forward lets A lead
	task enc_step(input int m, input logic forward);
		logic [1:0] ab;
		if (forward) begin
			enc_phase[m] = (enc_phase[m] + 1) % 4;
			enc_expect[m] = enc_expect[m] + 1;
		end else begin
			enc_phase[m] = (enc_phase[m] + 3) % 4;
			enc_expect[m] = enc_expect[m] - 1;
		end
		case (enc_phase[m])
			0: ab = 2'b00;
			1: ab = 2'b10;
			2: ab = 2'b11;
			default: ab = 2'b01;
		endcase
		@(posedge sysclk);
		enc_a[m] <= ab[1];
		enc_b[m] <= ab[0];
		repeat (4) @(posedge sysclk);
	endtask

	task check_outputs(input bridge_t gates, input logic charge);
		for (int m = 0; m < `NUM_MOTORS; m++) begin
			if (bridge[m] !== gates) begin
				report_mismatch($sformatf("bridge[%0d]", m), bridge[m], gates);
			end
		end
		if (kcharge !== charge) begin
			report_mismatch("kcharge", kcharge, charge);
		end
		if (kkick !== 1'b0 || kchip !== 1'b0) begin
			report_mismatch("{kkick, kchip}", {kkick, kchip}, 2'b00);
		end
	endtask

	task reset_state_test();
		test_start_errors = errors;
		@(negedge sysclk);
		if (miso_en !== 1'b0) begin
			report_mismatch("miso_en", miso_en, 1'b0);
		end
		check_outputs('0, 1'b0);
		read_status();
		if (rx_buf[0] !== `SPI_VERSION) begin
			report_mismatch("status byte 0", rx_buf[0], `SPI_VERSION);
		end
		for (int n = 1; n < STATUS_BYTES; n++) begin
			if (rx_buf[n] !== 8'h00) begin
				report_mismatch($sformatf("status byte %0d", n), rx_buf[n], 8'h00);
			end
		end
		finish_test("test 1 reset state");
	endtask

	task commutation_test();
		bridge_t gates;
		test_start_errors = errors;
		for (int d = 0; d < 2; d++) begin
			send_command(9'd511, d[0], 1'b0, 1'b0, 8'h00);
			for (int i = 0; i < 6; i++) begin
				hall_step(0, step_hall[i]);
				hall_step(1, step_hall[i]);
				gates = expected_gates(step_hall[i], d[0], 1'b1);
				check_outputs(gates, 1'b0);
			end
		end
		hall_step(0, 3'b111);
		if (bridge[0] !== 6'b0) begin
			report_mismatch("bridge[0]", bridge[0], 6'b0);
		end
		read_status();
		if (rx_buf[5] !== 8'h01) begin
			report_mismatch("fault byte", rx_buf[5], 8'h01);
		end
		hall_step(0, 3'b101);
		finish_test("test 2 commutation");
	endtask

	task pwm_duty_test();
		speed_t speed;
		int on_count[`NUM_MOTORS];
		int expected_on;
		int lit;
		test_start_errors = errors;
		hall_step(0, 3'b101);
		hall_step(1, 3'b101);
		speed = speed_t'(1 + $unsigned($random(seed)) % 509);
		expected_on = 2 * int'(speed) - 1;
		send_command(speed, 1'b0, 1'b0, 1'b0, 8'h00);
		repeat (8) @(posedge sysclk);
		for (int m = 0; m < `NUM_MOTORS; m++) begin
			on_count[m] = 0;
		end
		for (int c = 0; c < PWM_PERIOD; c++) begin
			@(negedge sysclk);
			for (int m = 0; m < `NUM_MOTORS; m++) begin
				// Hall 101 forward switches high A and keeps low B on
				if (bridge[m][5]) begin
					on_count[m]++;
				end
				if (bridge[m][4:0] !== 5'b00100) begin
					report_mismatch($sformatf("bridge[%0d][4:0]", m), bridge[m][4:0], 5'b00100);
				end
			end
		end
		for (int m = 0; m < `NUM_MOTORS; m++) begin
			if (on_count[m] != expected_on) begin
				report_mismatch($sformatf("bridge[%0d] high A on-cycles", m), on_count[m],
					expected_on);
			end
		end
		send_command(9'd0, 1'b0, 1'b0, 1'b0, 8'h00);
		repeat (8) @(posedge sysclk);
		lit = 0;
		for (int c = 0; c < PWM_PERIOD; c++) begin
			@(negedge sysclk);
			if (bridge !== '0) begin
				lit++;
			end
		end
		if (lit != 0) begin
			report_failure($sformatf("gates were on for %0d cycles at speed 0", lit));
		end
		finish_test($sformatf("test 3 pwm duty at speed %0d", speed));
	endtask

	task encoder_test();
		int steps;
		enc_count_t expected;
		test_start_errors = errors;
		for (int m = 0; m < `NUM_MOTORS; m++) begin
			steps = 20 + $unsigned($random(seed)) % 60;
			for (int s = 0; s < steps; s++) begin
				// Encoder 1 runs mostly forward and encoder 2 mostly backward
				if (m == 0) begin
					enc_step(m, ($unsigned($random(seed)) % 4) != 0);
				end else begin
					enc_step(m, ($unsigned($random(seed)) % 4) == 0);
				end
			end
		end
		read_status();
		for (int m = 0; m < `NUM_MOTORS; m++) begin
			expected = enc_count_t'(enc_expect[m]);
			if ({rx_buf[2 * m + 2], rx_buf[2 * m + 1]} !== expected) begin
				report_mismatch($sformatf("encoder %0d count", m + 1),
					{rx_buf[2 * m + 2], rx_buf[2 * m + 1]}, expected);
			end
		end
		finish_test("test 4 encoders");
	endtask

	task kick_test();
		byte_t strength;
		int waited;
		int pulse;
		int lockout;
		int bad;
		test_start_errors = errors;
		strength = byte_t'(1 + $unsigned($random(seed)) % 40);
		send_command(9'd0, 1'b0, 1'b1, 1'b1, strength);
		waited = 0;
		@(negedge sysclk);
		while (!kchip && waited < 20) begin
			@(negedge sysclk);
			waited++;
		end
		if (!kchip) begin
			report_failure("kchip never rose after the kick frame");
		end else begin
			pulse = 0;
			while (kchip && pulse < 2000) begin
				if (kkick !== 1'b0) begin
					report_mismatch("kkick", kkick, 1'b0);
				end
				if (kcharge !== 1'b0) begin
					report_mismatch("kcharge", kcharge, 1'b0);
				end
				pulse++;
				@(negedge sysclk);
			end
			if (pulse != int'(strength) * `KICK_TICK) begin
				report_mismatch("kchip high cycles", pulse, int'(strength) * `KICK_TICK);
			end
			lockout = 0;
			while (!kcharge && lockout < 1000) begin
				lockout++;
				@(negedge sysclk);
			end
			if (lockout != `KICK_LOCKOUT) begin
				report_mismatch("kcharge low cycles after kchip", lockout, `KICK_LOCKOUT);
			end
		end
		// Short frame that would drive the motors and stop charging
		tx_buf[0] = 8'hff;
		tx_buf[1] = 8'h03;
		tx_buf[2] = 8'hff;
		tx_buf[3] = 8'h03;
		spi_frame(4);
		bad = 0;
		for (int c = 0; c < 40; c++) begin
			@(negedge sysclk);
			if (bridge !== '0 || kcharge !== 1'b1 || kkick !== 1'b0 || kchip !== 1'b0) begin
				bad++;
			end
		end
		if (bad != 0) begin
			report_failure($sformatf("four-byte frame changed the outputs for %0d cycles", bad));
		end
		finish_test($sformatf("test 5 chip kick at strength %0d", strength));
	endtask

	task watchdog_test();
		bridge_t gates;
		test_start_errors = errors;
		gates = expected_gates(3'b101, 1'b0, 1'b1);
		send_command(9'd511, 1'b0, 1'b1, 1'b0, 8'h00);
		repeat (6) @(posedge sysclk);
		@(negedge sysclk);
		check_outputs(gates, 1'b1);
		// Still driving shortly before the watchdog period ends
		repeat (`WDOG_CYCLES - 100) @(posedge sysclk);
		@(negedge sysclk);
		check_outputs(gates, 1'b1);
		repeat (200) @(posedge sysclk);
		@(negedge sysclk);
		check_outputs('0, 1'b0);
		send_command(9'd511, 1'b0, 1'b1, 1'b0, 8'h00);
		repeat (6) @(posedge sysclk);
		@(negedge sysclk);
		check_outputs(gates, 1'b1);
		finish_test("test 6 command watchdog");
	endtask

	initial begin
		seed = 9;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		test_start_errors = 0;
		hall = {`NUM_MOTORS{3'b101}};
		enc_a = '0;
		enc_b = '0;
		// Button and done inputs idle high
		discharge = 1'b1;
		kdone = 1'b1;
		fpga_ncs = 1'b1;
		mosi = 1'b0;
		sck = 1'b0;
		for (int n = 0; n < 8; n++) begin
			tx_buf[n] = 8'h00;
			rx_buf[n] = 8'h00;
		end
		for (int m = 0; m < `NUM_MOTORS; m++) begin
			enc_phase[m] = 0;
			enc_expect[m] = 0;
		end
		@(posedge arst_n);
		repeat (4) @(posedge sysclk);
		reset_state_test();
		commutation_test();
		pwm_duty_test();
		encoder_test();
		kick_test();
		watchdog_test();
		$display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		#(RUN_CYCLES * CLK_NS);
		$display("Timeout: tests did not finish within %0d cycles", RUN_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
robo_pkg.sv
spi_target.sv
drive_timebase.sv
command_regs.sv
bldc_commutator.sv
quad_encoder.sv
kicker_fsm.sv
robo_top.sv
tb_clock.sv
tb_robo.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_robo -f flist.f
./obj_dir/Vtb_robo > sim.log
cat sim.log

if grep -q "Result: FAILED" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi
echo "Simulation finished without failure"
